// ==== src/issue_config.svh ====
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// word widths.
`define INST_WIDTH 32
`define ADDR_WIDTH 16
`define TS_WIDTH   48
`define TAG_WIDTH  4

// opcode field in the instruction word.
`define OPCODE_MSB 31
`define OPCODE_LSB 26

// branch-class ops hiding in the alu quadrants.
`define OP_CMP   6'b001010
`define OP_TEST  6'b001011
`define OP_CMPI  6'b011010
`define OP_TESTI 6'b011011

`define NOP_INST  32'h0000_0000
`define SLOT0_TAG 4'd2
`define SLOT1_TAG 4'd3

`endif

// ==== src/isa_pkg.sv ====
`default_nettype none

`include "issue_config.svh"

package isa_pkg;

  // one instruction word.
  typedef logic [`INST_WIDTH-1:0] inst_t;

  typedef logic [`OPCODE_MSB-`OPCODE_LSB:0] opcode_t;

  // word address into instruction memory.
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // which pipe an instruction must go to.
  // pipe_none runs on either lane.
  typedef enum logic [1:0] {
    pipe_none,
    pipe_branch,
    pipe_memory
  } pipe_class_e;

endpackage

`default_nettype wire

// ==== src/issue_pkg.sv ====
`default_nettype none

`include "issue_config.svh"

package issue_pkg;

  import isa_pkg::*;

  typedef logic [`TS_WIDTH-1:0] ts_t; // free-running cycle count.

  // slot tag on top, low timestamp bits below.
  typedef logic [`TAG_WIDTH+`TS_WIDTH-1:0] inst_id_t;

  // what leaves the front end on each lane.
  typedef struct packed {
    inst_t    inst;
    addr_t    pc;
    inst_id_t id;
  } issue_lane_t;

  // router output, before the id is stamped.
  typedef struct packed {
    inst_t inst;
    addr_t pc;
    logic  slot; // fetch slot it came from.
  } steer_lane_t;

  typedef enum logic {
    st_pair,
    st_second
  } split_state_e;

endpackage

`default_nettype wire

// ==== src/issue_steer.sv ====
`default_nettype none

`include "issue_config.svh"

module issue_steer
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  inst_t       inst0,
  input  inst_t       inst1,
  input  addr_t       pc,
  input  logic        second_half,
  output steer_lane_t steer0,
  output steer_lane_t steer1,
  output logic        conflict
);

  localparam steer_lane_t nop_lane = '{inst: `NOP_INST, pc: '0, slot: 1'b0};

  pipe_class_e cls0;
  pipe_class_e cls1;
  pipe_class_e lane0_cls;
  steer_lane_t src0;
  steer_lane_t src1;

  function automatic pipe_class_e classify(input inst_t inst);
    opcode_t op;
    op = inst[`OPCODE_MSB:`OPCODE_LSB];
    if (op == '0) begin
      classify = pipe_none;
    end else if (op == `OP_CMP || op == `OP_TEST) begin
      classify = pipe_branch;
    end else if (op == `OP_CMPI || op == `OP_TESTI) begin
      classify = pipe_branch;
    end else begin
      case (op[5:4])
        2'b10:   classify = pipe_memory; // loads and stores.
        2'b11:   classify = pipe_branch; // jumps.
        default: classify = pipe_none;
      endcase
    end
  endfunction

  assign cls0 = classify(inst0);
  assign cls1 = classify(inst1);

  // slot 1 lives one word above the pair address.
  assign src0 = '{inst: inst0, pc: pc, slot: 1'b0};
  assign src1 = '{inst: inst1, pc: pc + addr_t'(1), slot: 1'b1};

  assign conflict = (cls0 == cls1) && (cls0 != pipe_none);

  always_comb begin
    steer0 = src0;
    steer1 = src1;
    case ({cls0, cls1})
      {pipe_branch, pipe_branch}: begin
        steer0 = second_half ? src1 : src0; // both on lane 0, one per cycle.
        steer1 = nop_lane;
      end
      {pipe_memory, pipe_memory}: begin
        steer0 = nop_lane;
        steer1 = second_half ? src1 : src0;
      end
      {pipe_memory, pipe_branch},
      {pipe_memory, pipe_none},
      {pipe_none, pipe_branch}: begin
        steer0 = src1; // swap.
        steer1 = src0;
      end
      default: begin
        steer0 = src0;
        steer1 = src1;
      end
    endcase
  end

  assign lane0_cls = classify(steer0.inst);

  // the branch pipe never gets a load or store, split or not.
  a_no_mem_lane0: assert final (lane0_cls != pipe_memory);

endmodule

`default_nettype wire

// ==== src/split_fsm.sv ====
`default_nettype none

module split_fsm
  import issue_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic conflict,
  input  logic stall,
  output logic second_half,
  output logic hold_pc
);

  split_state_e state;
  split_state_e state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      st_pair: begin
        if (conflict) begin
          state_nxt = st_second;
        end
      end
      st_second: state_nxt = st_pair; // second half always takes one cycle.
      default:   state_nxt = st_pair;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_pair;
    end else if (!stall) begin
      state <= state_nxt;
    end
  end

  assign second_half = (state == st_second);
  assign hold_pc     = (state == st_pair) && conflict; // keep the pair for another cycle.

  // pc is held, so the same conflicting pair must still be on the fetch bus.
  a_second_has_conflict: assert property (
    @(posedge clk) disable iff (!arst_n)
    state == st_second |-> conflict
  );

endmodule

`default_nettype wire

// ==== src/fetch_counter.sv ====
`default_nettype none

module fetch_counter
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  stall,
  input  logic  hold_pc,
  output addr_t fetch_pc,
  output ts_t   timestamp
);

  // pair address, steps a full pair at a time.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_pc <= '0;
    end else if (!stall && !hold_pc) begin
      fetch_pc <= fetch_pc + addr_t'(2);
    end
  end

  // runs through stalls too.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      timestamp <= '0;
    end else begin
      timestamp <= timestamp + ts_t'(1);
    end
  end

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!arst_n)
    fetch_pc[0] == 1'b0
  );

endmodule

`default_nettype wire

// ==== src/issue_stage_reg.sv ====
`default_nettype none

`include "issue_config.svh"

module issue_stage_reg
  import issue_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        stall,
  input  steer_lane_t steer0,
  input  steer_lane_t steer1,
  input  ts_t         timestamp,
  output issue_lane_t lane0,
  output issue_lane_t lane1
);

  localparam issue_lane_t idle_lane = '{inst: `NOP_INST, pc: '0, id: '0};

  // tag by fetch slot, empty lanes carry no id.
  function automatic issue_lane_t stamp(input steer_lane_t s, input ts_t ts);
    inst_id_t id;
    if (s.inst == `NOP_INST) begin
      id = '0;
    end else begin
      id = {(s.slot ? `SLOT1_TAG : `SLOT0_TAG), ts};
    end
    stamp = '{inst: s.inst, pc: s.pc, id: id};
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lane0 <= idle_lane;
      lane1 <= idle_lane;
    end else if (!stall) begin
      lane0 <= stamp(steer0, timestamp);
      lane1 <= stamp(steer1, timestamp);
    end
  end

  // lane 1 is the memory pipe, a jump there means the router got it wrong.
  a_no_jump_lane1: assert property (
    @(posedge clk) disable iff (!arst_n)
    lane1.inst[`OPCODE_MSB:`OPCODE_MSB-1] != 2'b11
  );

endmodule

`default_nettype wire

// ==== src/dual_issue_frontend.sv ====
`default_nettype none

module dual_issue_frontend
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        stall,
  input  inst_t       inst0,
  input  inst_t       inst1,
  output addr_t       fetch_pc,
  output issue_lane_t lane0,
  output issue_lane_t lane1,
  output logic        split_busy
);

  ts_t         timestamp;
  steer_lane_t steer0;
  steer_lane_t steer1;
  logic        conflict;
  logic        second_half;
  logic        hold_pc;

  fetch_counter u_fetch_counter (
    .clk       (clk),
    .arst_n    (arst_n),
    .stall     (stall),
    .hold_pc   (hold_pc),
    .fetch_pc  (fetch_pc),
    .timestamp (timestamp)
  );

  issue_steer u_issue_steer (
    .inst0       (inst0),
    .inst1       (inst1),
    .pc          (fetch_pc),
    .second_half (second_half),
    .steer0      (steer0),
    .steer1      (steer1),
    .conflict    (conflict)
  );

  split_fsm u_split_fsm (
    .clk         (clk),
    .arst_n      (arst_n),
    .conflict    (conflict),
    .stall       (stall),
    .second_half (second_half),
    .hold_pc     (hold_pc)
  );

  issue_stage_reg u_issue_stage_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .stall     (stall),
    .steer0    (steer0),
    .steer1    (steer1),
    .timestamp (timestamp),
    .lane0     (lane0),
    .lane1     (lane1)
  );

  assign split_busy = hold_pc; // first half of a split pair is going out.

endmodule

`default_nettype wire

// ==== test/issue_checker.sv ====
`default_nettype none

`include "issue_config.svh"

module issue_checker
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        stall,
  input  addr_t       fetch_pc,
  input  issue_lane_t lane0,
  input  issue_lane_t lane1,
  input  logic        split_busy,
  output logic        done,
  output int          errors
);

  issue_lane_t exp0_q[$]; // id field unused here.
  issue_lane_t exp1_q[$];
  issue_lane_t last0;
  issue_lane_t last1;
  addr_t       last_pc;
  ts_t         last_ts;
  ts_t         exp_ts;  // timestamp the last edge stamped.
  logic        have_ts;
  logic        live;    // a clock edge out of reset has passed.
  logic        stalled; // stall seen by the last edge.
  int          split_seen;

  initial begin : load_expected
    int    fd;
    inst_t i0;
    inst_t i1;
    addr_t p0;
    addr_t p1;
    string line;
    done       = 1'b0;
    errors     = 0;
    live       = 1'b0;
    stalled    = 1'b0;
    have_ts    = 1'b0;
    exp_ts     = '0;
    split_seen = 0;
    fd = $fopen("test/issue_stimulus.txt", "r");
    if (fd == 0) begin
      $display("checker cannot open the stimulus file");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "E %h %h %h %h", i0, p0, i1, p1) == 4) begin
          exp0_q.push_back('{inst: i0, pc: p0, id: '0});
          exp1_q.push_back('{inst: i1, pc: p1, id: '0});
        end
      end
      $fclose(fd);
    end
  end

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (exp !== got) begin
      $display("[FAIL] %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_lane(input string name, input issue_lane_t exp, input issue_lane_t got);
    check_value({name, ".inst"}, 64'(exp.inst), 64'(got.inst));
    check_value({name, ".pc"}, 64'(exp.pc), 64'(got.pc));
    check_value({name, ".id"}, 64'(exp.id), 64'(got.id));
  endtask

  // tag follows the fetch slot, which the pc parity gives away.
  task automatic check_id(input string name, input issue_lane_t exp, input issue_lane_t got);
    logic [3:0] tag;
    tag = exp.pc[0] ? `SLOT1_TAG : `SLOT0_TAG;
    if (exp.inst == `NOP_INST) begin
      check_value({name, ".id"}, 64'(0), 64'(got.id));
    end else begin
      check_value({name, ".id"}, 64'({tag, exp_ts}), 64'(got.id));
    end
  endtask

  task automatic check_issue();
    issue_lane_t e0;
    issue_lane_t e1;
    ts_t         ts;
    if (exp0_q.size() == 0) begin
      $display("unexpected issue after the sequence ended, lane0 pc %h", lane0.pc);
      errors++;
    end else begin
      e0 = exp0_q.pop_front();
      e1 = exp1_q.pop_front();
      check_value("lane0.inst", 64'(e0.inst), 64'(lane0.inst));
      check_value("lane0.pc", 64'(e0.pc), 64'(lane0.pc));
      check_value("lane1.inst", 64'(e1.inst), 64'(lane1.inst));
      check_value("lane1.pc", 64'(e1.pc), 64'(lane1.pc));
      check_id("lane0", e0, lane0);
      check_id("lane1", e1, lane1);
      ts = (lane0.inst != `NOP_INST) ? lane0.id[`TS_WIDTH-1:0] : lane1.id[`TS_WIDTH-1:0];
      if (have_ts && ts <= last_ts) begin
        $display("[FAIL] issue timestamp %h not above previous %h", ts, last_ts);
        errors++;
      end
      last_ts = ts;
      have_ts = 1'b1;
      if (exp0_q.size() == 0) begin
        if (split_seen == 0) begin
          $display("split_busy never went high during the run");
          errors++;
        end
        done = 1'b1;
      end
    end
  endtask

  // lanes and pc settle well before the falling edge.
  always @(negedge clk) begin
    if (!arst_n) begin
      check_lane("lane0 in reset", '0, lane0);
      check_lane("lane1 in reset", '0, lane1);
      check_value("fetch_pc in reset", 64'(0), 64'(fetch_pc));
      live   = 1'b0;
      exp_ts = '0;
    end else begin
      if (live && stalled) begin
        check_lane("lane0 under stall", last0, lane0);
        check_lane("lane1 under stall", last1, lane1);
        check_value("fetch_pc under stall", 64'(last_pc), 64'(fetch_pc));
      end else if (live && (lane0.inst != `NOP_INST || lane1.inst != `NOP_INST)) begin
        check_issue();
      end
      if (split_busy) begin
        split_seen++;
      end
      if (live) begin
        exp_ts = exp_ts + ts_t'(1); // counts through stalls too.
      end
      live    = 1'b1;
      stalled = stall;
      last0   = lane0;
      last1   = lane1;
      last_pc = fetch_pc;
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_dual_issue_frontend.sv ====
`default_nettype none

`include "issue_config.svh"

module tb_dual_issue_frontend
  import isa_pkg::*;
  import issue_pkg::*;
();

  logic        clk;
  logic        arst_n;
  logic        stall;
  inst_t       inst0;
  inst_t       inst1;
  addr_t       fetch_pc;
  issue_lane_t lane0;
  issue_lane_t lane1;
  logic        split_busy;
  logic        chk_done;
  int          chk_errors;
  int          tb_errors;
  int          cycle;
  integer      seed;
  inst_t       prog_q[$];        // instruction memory, word per address.
  int          stall_start_q[$];
  int          stall_len_q[$];

  always #5 clk = ~clk;

  dual_issue_frontend dut0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .stall      (stall),
    .inst0      (inst0),
    .inst1      (inst1),
    .fetch_pc   (fetch_pc),
    .lane0      (lane0),
    .lane1      (lane1),
    .split_busy (split_busy)
  );

  issue_checker chk0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .stall      (stall),
    .fetch_pc   (fetch_pc),
    .lane0      (lane0),
    .lane1      (lane1),
    .split_busy (split_busy),
    .done       (chk_done),
    .errors     (chk_errors)
  );

  // past the end of the program memory reads as nop.
  function automatic inst_t read_word(input addr_t addr);
    if (int'(addr) < prog_q.size()) begin
      read_word = prog_q[addr];
    end else begin
      read_word = `NOP_INST;
    end
  endfunction

  function automatic logic in_window(input int c);
    in_window = 1'b0;
    foreach (stall_start_q[i]) begin
      if (c >= stall_start_q[i] && c < stall_start_q[i] + stall_len_q[i]) begin
        in_window = 1'b1;
      end
    end
  endfunction

  task automatic load_stimulus();
    int    fd;
    int    a;
    int    b;
    inst_t w0;
    inst_t w1;
    string line;
    fd = $fopen("test/issue_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file test/issue_stimulus.txt");
      tb_errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "P %h %h", w0, w1) == 2) begin
          prog_q.push_back(w0);
          prog_q.push_back(w1);
        end else if ($sscanf(line, "S %d %d", a, b) == 2) begin
          stall_start_q.push_back(a);
          stall_len_q.push_back(b);
        end
      end
      $fclose(fd);
    end
  endtask

  // memory answers the current pair, then pick this cycle's stall.
  task automatic drive_inputs();
    logic [31:0] rnd;
    rnd   = $random(seed);
    inst0 = read_word(fetch_pc);
    inst1 = read_word(fetch_pc + addr_t'(1));
    stall = in_window(cycle) || (!stall && rnd[3:0] == 4'h0); // lone random stalls.
  endtask

  initial begin : run
    int waited;
    clk       = 1'b0;
    arst_n    = 1'b0;
    stall     = 1'b0;
    inst0     = `NOP_INST;
    inst1     = `NOP_INST;
    tb_errors = 0;
    cycle     = 0;
    waited    = 0;
    seed      = 32'h4c7a;
    load_stimulus();
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    drive_inputs();
    while (!chk_done && waited < 2000) begin
      @(posedge clk);
      #1;
      cycle++;
      waited++;
      drive_inputs();
    end
    if (!chk_done) begin
      $display("timed out after %0d cycles waiting for the issue sequence to finish", waited);
      tb_errors++;
    end
    $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/issue_stimulus.txt ====
# P <word at pc> <word at pc+1> in hex, S <start cycle> <length> in decimal
# E <lane0 inst> <lane0 pc> <lane1 inst> <lane1 pc> in hex, one line per issue
P 04000011 44000022
P 80000033 04000044
P 08000055 C0000066
P 28000077 68000088
P 80000099 840000AA
P 2C0000BB 880000CC
P 6C0000DD 480000EE
P 8C000102 E0000113
P C4000124 FC000135
P 10000146 5C000157
S 5 4
S 14 3
E 04000011 0000 44000022 0001
E 04000044 0003 80000033 0002
E C0000066 0005 08000055 0004
E 28000077 0006 00000000 0000
E 68000088 0007 00000000 0000
E 00000000 0000 80000099 0008
E 00000000 0000 840000AA 0009
E 2C0000BB 000A 880000CC 000B
E 6C0000DD 000C 480000EE 000D
E E0000113 000F 8C000102 000E
E C4000124 0010 00000000 0000
E FC000135 0011 00000000 0000
E 10000146 0012 5C000157 0013

// ==== dual_issue_frontend.f ====
+incdir+src
src/isa_pkg.sv
src/issue_pkg.sv
src/issue_steer.sv
src/split_fsm.sv
src/fetch_counter.sv
src/issue_stage_reg.sv
src/dual_issue_frontend.sv
test/issue_checker.sv
test/tb_dual_issue_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_dual_issue_frontend
FILELIST  ?= dual_issue_frontend.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Verification failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; echo "exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "exit status 0" $(LOG); then echo "simulation ended abnormally"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
